// ==== Makefile ====
TOP := exec_cluster_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// ==== dv/exec_cluster_props.sv ====
// handshake properties for the execute cluster, bound into exec_cluster
// port names match the unit and arbiter nets inside exec_cluster
`timescale 1ns/10ps

module exec_cluster_props (
	input logic              clk,
	input logic              reset,
	input logic              add_valid,
	input logic              add_yumi,
	input cdb_pkg::cdb_pkt_t add_pkt,
	input logic              logic_valid,
	input logic              logic_yumi,
	input cdb_pkg::cdb_pkt_t logic_pkt,
	input logic              cdb_stall,
	input logic              cdb_valid
);

	// a held result stays put until the arbiter takes it
	add_hold: assert property (@(posedge clk) disable iff (reset)
		add_valid && !add_yumi |=> add_valid && $stable(add_pkt))
		else $error("add unit result dropped or changed before yumi");

	logic_hold: assert property (@(posedge clk) disable iff (reset)
		logic_valid && !logic_yumi |=> logic_valid && $stable(logic_pkt))
		else $error("logic unit result dropped or changed before yumi");

	// a contested grant empties exactly one unit
	one_yumi: assert property (@(posedge clk) disable iff (reset)
		add_valid && logic_valid && cdb_valid |=> add_valid != logic_valid)
		else $error("contested grant did not release exactly one unit");

	no_bus_in_stall: assert property (@(posedge clk) disable iff (reset)
		cdb_stall |-> !cdb_valid)
		else $error("CDB driven while stalled");

endmodule

// ==== dv/exec_cluster_tb.sv ====
// random issues and CDB stalls against a reference model of the execute cluster
// ROB tags stay unique among in-flight operations, results are matched by tag
`timescale 1ns/10ps
`include "exec_cfg.svh"

module exec_cluster_tb;
	import exec_types_pkg::*;
	import cdb_pkg::*;

	localparam int XLEN = `EXEC_XLEN;
	localparam int ROBS = 1 << `EXEC_ROB_BITS;
	localparam int SHW = $clog2(XLEN);
	localparam int N_ISSUES = 400;
	localparam int HOLD_LIMIT = 100;
	localparam int DRAIN_LIMIT = 100;
	localparam int RUN_LIMIT = 20000;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [`EXEC_ROB_BITS-1:0] rob_t;

	localparam word_t ONES = '1;

	logic       clk;
	logic       reset;
	logic       issue_valid;
	issue_pkt_t issue;
	logic       cdb_stall;
	logic       issue_ready;
	logic       cdb_valid;
	cdb_pkt_t   cdb_pkt;

	// model state by ROB tag
	logic     exp_live [ROBS];
	cdb_pkt_t exp_pkt [ROBS];
	logic     exp_is_add [ROBS];
	alu_op_e  exp_op [ROBS];
	logic     add_busy;
	logic     logic_busy;
	logic     next_add;    // add unit wins the next tie
	logic     took_issue;  // accepted at the coming edge
	int       accepted;

	exec_cluster UUT (
		.clk         (clk),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue       (issue),
		.cdb_stall   (cdb_stall),
		.issue_ready (issue_ready),
		.cdb_valid   (cdb_valid),
		.cdb_pkt     (cdb_pkt)
	);

	bind exec_cluster exec_cluster_props u_props (
		.clk         (clk),
		.reset       (reset),
		.add_valid   (add_valid),
		.add_yumi    (add_yumi),
		.add_pkt     (add_pkt),
		.logic_valid (logic_valid),
		.logic_yumi  (logic_yumi),
		.logic_pkt   (logic_pkt),
		.cdb_stall   (cdb_stall),
		.cdb_valid   (cdb_valid)
	);

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input word_t expected, input word_t actual);
		assert (expected === actual) else begin
			$display("Mismatch %s: expected %0h, actual %0h", test, expected, actual);
			abort_run();
		end
	endtask

	function automatic logic is_add_op(input alu_op_e op);
		return (op == OP_ADD) || (op == OP_SUB) || (op == OP_BEQ) ||
			(op == OP_BNE) || (op == OP_BLT);
	endfunction

	function automatic cdb_pkt_t model_result(input issue_pkt_t p);
		cdb_pkt_t       r;
		word_t          diff;
		word_t          sign_fill;
		logic [SHW-1:0] sh;
		r = '0;
		r.rob = p.rob;
		diff = p.rs1 - p.rs2;
		sh = p.rs2[SHW-1:0];
		sign_fill = p.rs1[XLEN-1] ? ~(ONES >> sh) : '0;
		case (p.op)
			OP_ADD: r.result = p.rs1 + p.rs2;
			OP_SUB: r.result = diff;
			OP_AND: r.result = p.rs1 & p.rs2;
			OP_OR:  r.result = p.rs1 | p.rs2;
			OP_XOR: r.result = p.rs1 ^ p.rs2;
			OP_SLL: r.result = p.rs1 << sh;
			OP_SRL: r.result = p.rs1 >> sh;
			OP_SRA: r.result = (p.rs1 >> sh) | sign_fill;
			OP_BEQ: begin
				r.result = diff;
				r.branch_taken = (p.rs1 == p.rs2);
			end
			OP_BNE: begin
				r.result = diff;
				r.branch_taken = (p.rs1 != p.rs2);
			end
			OP_BLT: begin
				r.result = diff;
				r.branch_taken = ($signed(p.rs1) < $signed(p.rs2));
			end
			default: r.result = '0;
		endcase
		if (is_add_op(p.op))
			r.load_step1 = p.load;
		return r;
	endfunction

	function automatic issue_pkt_t random_issue();
		issue_pkt_t p;
		rob_t       tag;
		tag = rob_t'($urandom);
		for (int i = 0; i < ROBS; i++) begin
			if (exp_live[tag])
				tag = tag + 1'b1;  // skip tags still in flight
		end
		p.op = alu_op_e'(4'($urandom_range(10, 0)));
		p.rob = tag;
		p.rs1 = word_t'($urandom);
		p.rs2 = word_t'($urandom);
		if ((p.op == OP_BEQ || p.op == OP_BNE) && $urandom_range(3, 0) == 0)
			p.rs2 = p.rs1;  // hit the equal case
		p.load = (p.op == OP_ADD) && ($urandom_range(1, 0) == 1);
		return p;
	endfunction

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		int hold;
		int sent;
		int cycles;
		void'($urandom(32'h97689792));
		reset = 1'b1;
		issue_valid = 1'b0;
		issue = '0;
		cdb_stall = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		hold = 0;
		sent = 0;
		cycles = 0;
		while (accepted < N_ISSUES) begin
			@(posedge clk);
			cycles++;
			if (cycles > RUN_LIMIT) begin
				$display("only %0d of %0d issues accepted in %0d cycles",
					accepted, N_ISSUES, RUN_LIMIT);
				abort_run();
			end
			cdb_stall <= ($urandom_range(3, 0) == 0);
			if (issue_valid && !took_issue) begin
				hold++;  // same issue stays on the port
				if (hold > HOLD_LIMIT) begin
					$display("issue not accepted within %0d cycles", HOLD_LIMIT);
					abort_run();
				end
			end else if (sent < N_ISSUES && $urandom_range(9, 0) < 7) begin
				hold = 0;
				issue <= random_issue();
				issue_valid <= 1'b1;
				sent++;
			end else begin
				hold = 0;
				issue_valid <= 1'b0;
			end
		end
		cycles = 0;
		while (add_busy || logic_busy) begin
			@(posedge clk);
			cdb_stall <= ($urandom_range(3, 0) == 0);
			cycles++;
			if (cycles > DRAIN_LIMIT) begin
				$display("results still held %0d cycles after the last issue", DRAIN_LIMIT);
				abort_run();
			end
		end
		@(posedge clk);
		cdb_stall <= 1'b0;
		repeat (4) @(posedge clk);  // bus must stay idle
		$display("TB PASSED");
		$finish;
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		cdb_pkt_t want;
		alu_op_e  op_seen;
		string    name;
		logic     to_add;
		logic     grant_add;
		if (reset) begin
			for (int i = 0; i < ROBS; i++) begin
				exp_live[i] = 1'b0;
			end
			add_busy = 1'b0;
			logic_busy = 1'b0;
			next_add = 1'b1;
			took_issue = 1'b0;
			accepted = 0;
		end else begin
			to_add = is_add_op(issue.op);
			check_value("issue_ready", word_t'(to_add ? !add_busy : !logic_busy),
				word_t'(issue_ready));
			check_value("cdb_valid", word_t'((add_busy || logic_busy) && !cdb_stall),
				word_t'(cdb_valid));
			if (cdb_valid) begin
				assert (exp_live[cdb_pkt.rob]) else begin
					$display("CDB result for ROB tag %0d with no operation in flight",
						cdb_pkt.rob);
					abort_run();
				end
				want = exp_pkt[cdb_pkt.rob];
				op_seen = exp_op[cdb_pkt.rob];
				name = $sformatf("%s rob %0d", op_seen.name(), cdb_pkt.rob);
				check_value({name, " result"}, want.result, cdb_pkt.result);
				check_value({name, " branch_taken"}, word_t'(want.branch_taken),
					word_t'(cdb_pkt.branch_taken));
				check_value({name, " load_step1"}, word_t'(want.load_step1),
					word_t'(cdb_pkt.load_step1));
				check_value({name, " from_memory"}, word_t'(want.from_memory),
					word_t'(cdb_pkt.from_memory));
				grant_add = exp_is_add[cdb_pkt.rob];
				if (add_busy && logic_busy) begin
					check_value("round-robin grant to add unit", word_t'(next_add),
						word_t'(grant_add));
					next_add = !grant_add;
				end
				exp_live[cdb_pkt.rob] = 1'b0;
				if (grant_add)
					add_busy = 1'b0;
				else
					logic_busy = 1'b0;
			end
			took_issue = issue_valid && issue_ready;
			if (took_issue) begin
				exp_live[issue.rob] = 1'b1;
				exp_pkt[issue.rob] = model_result(issue);
				exp_is_add[issue.rob] = to_add;
				exp_op[issue.rob] = issue.op;
				if (to_add)
					add_busy = 1'b1;
				else
					logic_busy = 1'b1;
				accepted++;
			end
		end
	end

endmodule

// ==== files.f ====
+incdir+source
source/exec_types_pkg.sv
source/cdb_pkg.sv
source/add_unit.sv
source/logic_unit.sv
source/cdb_arbiter.sv
source/exec_cluster.sv
dv/exec_cluster_props.sv
dv/exec_cluster_tb.sv

// ==== source/add_unit.sv ====
// add/sub unit, also resolves branches and forms load addresses
// holds one result, ready only while empty, cleared by yumi
// branches always subtract so the flags compare rs1 against rs2
`timescale 1ns/10ps
`include "exec_cfg.svh"

module add_unit (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       valid_in,
	input  logic                       yumi,
	input  exec_types_pkg::issue_pkt_t issue,
	output logic                       valid_out,
	output logic                       ready,
	output cdb_pkg::cdb_pkt_t          out
);
	import exec_types_pkg::*;

	logic [`EXEC_XLEN-1:0] sum;
	logic                  zero;
	logic                  negative;
	logic                  overflow;
	logic                  is_branch;
	logic                  sub;
	logic                  taken;
	logic                  take;

	assign is_branch = (issue.op == OP_BEQ) || (issue.op == OP_BNE) || (issue.op == OP_BLT);
	assign sub = is_branch || (issue.op == OP_SUB);

	add_ripple #(.W(`EXEC_XLEN)) adder (
		.a        (issue.rs1),
		.b        (issue.rs2),
		.sub      (sub),
		.sum      (sum),
		.zero     (zero),
		.negative (negative),
		.overflow (overflow)
	);

	always_comb begin
		case (issue.op)
			OP_BEQ:  taken = zero;
			OP_BNE:  taken = ~zero;
			OP_BLT:  taken = negative ^ overflow;  // signed less-than
			default: taken = 1'b0;
		endcase
	end

	assign ready = ~valid_out;  // empty slot
	assign take = valid_in && ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else if (yumi) begin
			valid_out <= 1'b0;
		end else if (take) begin
			valid_out <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out.rob          <= issue.rob;
			out.result       <= sum;
			out.branch_taken <= taken;
			out.load_step1   <= issue.load;
			out.from_memory  <= 1'b0;
		end
	end
endmodule

// ripple-carry adder, b is inverted and carry-in set for subtract
module add_ripple #(
	parameter int W = `EXEC_XLEN
) (
	input  logic [W-1:0] a,
	input  logic [W-1:0] b,
	input  logic         sub,
	output logic [W-1:0] sum,
	output logic         zero,
	output logic         negative,
	output logic         overflow
);
	logic [W:0]   carry;
	logic [W-1:0] b_eff;

	assign b_eff = sub ? ~b : b;
	assign carry[0] = sub;

	for (genvar i = 0; i < W; i++) begin : g_bit
		assign sum[i] = a[i] ^ b_eff[i] ^ carry[i];
		assign carry[i+1] = (a[i] & b_eff[i]) | (carry[i] & (a[i] ^ b_eff[i]));
	end

	assign zero = (sum == '0);
	assign negative = sum[W-1];
	assign overflow = carry[W] ^ carry[W-1];  // carry into and out of sign bit
endmodule

// ==== source/cdb_arbiter.sv ====
// round-robin CDB arbiter for the two units, one result per cycle
// grant, yumi and the bus are combinational from the unit valids
// nothing is granted while cdb_stall is high
`timescale 1ns/10ps

module cdb_arbiter (
	input  logic              clk,
	input  logic              reset,
	input  logic              add_valid,
	input  cdb_pkg::cdb_pkt_t add_pkt,
	input  logic              logic_valid,
	input  cdb_pkg::cdb_pkt_t logic_pkt,
	input  logic              cdb_stall,
	output logic              add_yumi,
	output logic              logic_yumi,
	output logic              cdb_valid,
	output cdb_pkg::cdb_pkt_t cdb_pkt
);
	import cdb_pkg::*;

	arb_pri_e pri;
	logic     both;
	logic     grant_add;

	assign both = add_valid && logic_valid;

	// add wins when alone or when it holds priority
	assign grant_add = add_valid && (!logic_valid || (pri == PRI_ADD));

	assign cdb_valid = (add_valid || logic_valid) && !cdb_stall;
	assign add_yumi = cdb_valid && grant_add;
	assign logic_yumi = cdb_valid && !grant_add;
	assign cdb_pkt = grant_add ? add_pkt : logic_pkt;

	// flip only after a contested grant
	always_ff @(posedge clk) begin
		if (reset) begin
			pri <= PRI_ADD;
		end else if (both && !cdb_stall) begin
			pri <= (pri == PRI_ADD) ? PRI_LOGIC : PRI_ADD;
		end
	end
endmodule

// ==== source/cdb_pkg.sv ====
// common data bus types
// from_memory is kept for the load unit, this cluster always drives 0
`include "exec_cfg.svh"

package cdb_pkg;

	// one broadcast result
	typedef struct packed {
		logic [`EXEC_ROB_BITS-1:0] rob;
		logic [`EXEC_XLEN-1:0]     result;
		logic                      branch_taken;
		logic                      load_step1;   // result is a load address
		logic                      from_memory;
	} cdb_pkt_t;

	// which unit wins the next tie
	typedef enum logic {
		PRI_ADD   = 1'b0,
		PRI_LOGIC = 1'b1
	} arb_pri_e;

endpackage

// ==== source/exec_cfg.svh ====
// widths shared by the execute cluster
// EXEC_XLEN must be a power of two, shifts use its low log2 bits of rs2
// EXEC_ROB_BITS sizes the ROB tag carried from issue to the CDB
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// operand and result width
`define EXEC_XLEN 32

// reorder buffer tag width
`define EXEC_ROB_BITS 4

`endif

// ==== source/exec_cluster.sv ====
// execute stage with an add/branch unit and a logic/shift unit
// each issue goes to one unit by opcode, issue_ready follows that unit
// at most one operation in flight per unit
`timescale 1ns/10ps

module exec_cluster (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       issue_valid,
	input  exec_types_pkg::issue_pkt_t issue,
	input  logic                       cdb_stall,
	output logic                       issue_ready,
	output logic                       cdb_valid,
	output cdb_pkg::cdb_pkt_t          cdb_pkt
);
	import exec_types_pkg::*;
	import cdb_pkg::*;

	logic     to_add;
	logic     add_valid;
	logic     add_ready;
	logic     add_yumi;
	cdb_pkt_t add_pkt;
	logic     logic_valid;
	logic     logic_ready;
	logic     logic_yumi;
	cdb_pkt_t logic_pkt;

	always_comb begin
		case (issue.op)
			OP_ADD, OP_SUB, OP_BEQ, OP_BNE, OP_BLT: to_add = 1'b1;
			default:                                to_add = 1'b0;  // bitwise and shifts
		endcase
	end

	assign issue_ready = to_add ? add_ready : logic_ready;

	add_unit u_add (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (issue_valid && to_add),
		.yumi      (add_yumi),
		.issue     (issue),
		.valid_out (add_valid),
		.ready     (add_ready),
		.out       (add_pkt)
	);

	logic_unit u_logic (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (issue_valid && !to_add),
		.yumi      (logic_yumi),
		.issue     (issue),
		.valid_out (logic_valid),
		.ready     (logic_ready),
		.out       (logic_pkt)
	);

	cdb_arbiter u_arb (
		.clk         (clk),
		.reset       (reset),
		.add_valid   (add_valid),
		.add_pkt     (add_pkt),
		.logic_valid (logic_valid),
		.logic_pkt   (logic_pkt),
		.cdb_stall   (cdb_stall),
		.add_yumi    (add_yumi),
		.logic_yumi  (logic_yumi),
		.cdb_valid   (cdb_valid),
		.cdb_pkt     (cdb_pkt)
	);
endmodule

// ==== source/exec_types_pkg.sv ====
// issue side types for the execute cluster
// field widths come from exec_cfg.svh
`include "exec_cfg.svh"

package exec_types_pkg;

	// opcode as decoded by the reservation station
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_OR  = 4'd3,
		OP_XOR = 4'd4,
		OP_SLL = 4'd5,
		OP_SRL = 4'd6,
		OP_SRA = 4'd7,
		OP_BEQ = 4'd8,  // branches subtract and test flags
		OP_BNE = 4'd9,
		OP_BLT = 4'd10  // signed compare
	} alu_op_e;

	// one issued operation with its operands already read
	typedef struct packed {
		alu_op_e                   op;
		logic [`EXEC_ROB_BITS-1:0] rob;   // destination ROB entry
		logic [`EXEC_XLEN-1:0]     rs1;
		logic [`EXEC_XLEN-1:0]     rs2;
		logic                      load;  // address add for a load
	} issue_pkt_t;

endpackage

// ==== source/logic_unit.sv ====
// bitwise and shift unit, one result held until yumi
// shift amount is the low log2(EXEC_XLEN) bits of rs2
// opcodes outside its class produce a zero result
`timescale 1ns/10ps
`include "exec_cfg.svh"

module logic_unit (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       valid_in,
	input  logic                       yumi,
	input  exec_types_pkg::issue_pkt_t issue,
	output logic                       valid_out,
	output logic                       ready,
	output cdb_pkg::cdb_pkt_t          out
);
	import exec_types_pkg::*;

	localparam int SHAMT_W = $clog2(`EXEC_XLEN);

	logic [SHAMT_W-1:0]    shamt;
	logic [`EXEC_XLEN-1:0] res;
	logic                  take;

	assign shamt = issue.rs2[SHAMT_W-1:0];

	always_comb begin
		case (issue.op)
			OP_AND:  res = issue.rs1 & issue.rs2;
			OP_OR:   res = issue.rs1 | issue.rs2;
			OP_XOR:  res = issue.rs1 ^ issue.rs2;
			OP_SLL:  res = issue.rs1 << shamt;
			OP_SRL:  res = issue.rs1 >> shamt;
			OP_SRA:  res = $unsigned($signed(issue.rs1) >>> shamt);  // sign fill
			default: res = '0;
		endcase
	end

	assign ready = ~valid_out;
	assign take = valid_in && ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else if (yumi) begin
			valid_out <= 1'b0;
		end else if (take) begin
			valid_out <= 1'b1;
		end
	end

	// payload only, valid_out qualifies it
	always_ff @(posedge clk) begin
		if (take) begin
			out.rob          <= issue.rob;
			out.result       <= res;
			out.branch_taken <= 1'b0;
			out.load_step1   <= 1'b0;
			out.from_memory  <= 1'b0;
		end
	end
endmodule
